//--- rtl/trace_repo_pkg.sv
package trace_repo_pkg;

    // Address and instruction widths of one captured trace word
    parameter int DATA_ADDR_WIDTH = 16;
    parameter int DATA_DATA_WIDTH = 32;

    // Geometry of the on-chip trace store
    parameter int TRACE_ENTRIES = 64;
    parameter int TRACE_INDEX_WIDTH = $clog2(TRACE_ENTRIES);

    parameter int COUNTER_WIDTH = 32;

    // One stored trace word, also the shape of the issued entry
    typedef struct packed {
        logic [DATA_ADDR_WIDTH-1:0] mem_addr;
        logic [DATA_DATA_WIDTH-1:0] instruction;
    } trace_entry_t;

    // A completion report for one memory operation
    typedef struct packed {
        logic [TRACE_INDEX_WIDTH-1:0] index_done;
        logic [DATA_ADDR_WIDTH-1:0]   mem_addr;
        logic                         processing;  // Done by the pre-emptive engine
        logic                         mem_trace;   // Report comes from the trace side
        logic                         hit_miss;    // 1 is a miss
        logic                         load_store;  // 1 is a store
    } done_req_t;

    // In the outcome counters h is a plain hit and m is a plain miss, while hph and
    // hpm are system hits whose pre-emptive run hit or missed
    typedef struct packed {
        logic [COUNTER_WIDTH-1:0] h_l;
        logic [COUNTER_WIDTH-1:0] hph_l;
        logic [COUNTER_WIDTH-1:0] hpm_l;
        logic [COUNTER_WIDTH-1:0] h_s;
        logic [COUNTER_WIDTH-1:0] hph_s;
        logic [COUNTER_WIDTH-1:0] hpm_s;
        logic [COUNTER_WIDTH-1:0] m_l;
        logic [COUNTER_WIDTH-1:0] m_s;
    } outcome_counts_t;

endpackage

//--- rtl/trace_memory.sv
`timescale 1ns/1ps

module trace_memory
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        wr_en_i,
    input  trace_repo_pkg::trace_entry_t                wr_data_i,
    input  logic                                        rd_en_i,
    input  logic [trace_repo_pkg::TRACE_INDEX_WIDTH-1:0] rd_addr_i,
    output trace_repo_pkg::trace_entry_t                rd_data_o,
    output logic [trace_repo_pkg::TRACE_INDEX_WIDTH:0]  capture_count_o
);
    import trace_repo_pkg::*;

    localparam logic [TRACE_INDEX_WIDTH:0] FULL_COUNT = (TRACE_INDEX_WIDTH + 1)'(TRACE_ENTRIES);

    trace_entry_t                 mem_q [TRACE_ENTRIES];
    logic [TRACE_INDEX_WIDTH-1:0] wr_ptr;
    logic                         store_full;
    logic                         do_write;

    // The next free slot is the low part of the count
    assign wr_ptr     = capture_count_o[TRACE_INDEX_WIDTH-1:0];
    assign store_full = (capture_count_o == FULL_COUNT);
    assign do_write   = wr_en_i && !store_full;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            capture_count_o <= '0;
        end
        else if (do_write)
        begin
            capture_count_o <= capture_count_o + 1'b1;
        end
    end

    // Storage array and its registered read port
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem_q[wr_ptr] <= wr_data_i;
        end
        if (rd_en_i)
        begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

//--- rtl/trace_fetch.sv
`timescale 1ns/1ps

module trace_fetch
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        lock_i,
    input  logic                                        trace_req_i,
    input  logic                                        done_accept_i,
    input  logic [trace_repo_pkg::TRACE_INDEX_WIDTH:0]  capture_count_i,
    input  logic [trace_repo_pkg::TRACE_INDEX_WIDTH:0]  committed_count_i,
    input  trace_repo_pkg::trace_entry_t                rd_data_i,
    output logic                                        rd_en_o,
    output logic [trace_repo_pkg::TRACE_INDEX_WIDTH-1:0] rd_addr_o,
    output trace_repo_pkg::trace_entry_t                trace_o,
    output logic [trace_repo_pkg::TRACE_INDEX_WIDTH-1:0] trace_index_o,
    output logic                                        entry_valid_o,
    output logic                                        processing_complete_o
);
    import trace_repo_pkg::*;

    localparam logic [1:0] ST_LISTEN = 2'd0;
    localparam logic [1:0] ST_READ   = 2'd1;
    localparam logic [1:0] ST_LATCH  = 2'd2;

    logic [1:0]                 state_q;
    logic [TRACE_INDEX_WIDTH:0] action_ptr_q;
    logic [TRACE_INDEX_WIDTH:0] next_index;
    logic [TRACE_INDEX_WIDTH:0] fetch_index_q;
    logic [TRACE_INDEX_WIDTH:0] held_index_q;
    trace_entry_t               held_entry_q;
    logic                       held_valid_q;
    logic                       entry_ready;
    logic                       all_committed;
    logic                       serve;
    logic                       issue;

    // All ones in the action pointer means no entry has been acted on yet
    assign next_index = action_ptr_q + 1'b1;

    // A pending advance makes the held entry stale on the next edge
    assign entry_ready   = held_valid_q && (held_index_q == next_index) && !done_accept_i;
    assign all_committed = (committed_count_i == capture_count_i);
    assign serve         = lock_i && (state_q == ST_LISTEN) && trace_req_i && entry_ready;
    assign issue         = serve && !all_committed && !entry_valid_o;

    assign rd_en_o   = lock_i && (state_q == ST_READ);
    assign rd_addr_o = next_index[TRACE_INDEX_WIDTH-1:0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q               <= ST_LISTEN;
            action_ptr_q          <= '1;
            held_valid_q          <= 1'b0;
            entry_valid_o         <= 1'b0;
            processing_complete_o <= 1'b0;
        end
        else
        begin
            entry_valid_o <= issue;
            // Stays up for as long as the request is held and nothing is left
            processing_complete_o <= lock_i && trace_req_i && all_committed
                                     && (processing_complete_o || serve);
            if (done_accept_i)
            begin
                action_ptr_q <= next_index;
            end
            if (!lock_i)
            begin
                state_q      <= ST_LISTEN;
                held_valid_q <= 1'b0;
            end
            else
            begin
                case (state_q)
                    ST_LISTEN:
                    begin
                        if (!entry_ready)
                        begin
                            state_q <= ST_READ;
                        end
                    end
                    ST_READ:
                    begin
                        state_q <= ST_LATCH;
                    end
                    ST_LATCH:
                    begin
                        held_valid_q <= 1'b1;
                        state_q      <= ST_LISTEN;
                    end
                    default:
                    begin
                        state_q <= ST_LISTEN;
                    end
                endcase
            end
        end
    end

    // The index is latched together with the word so a mid-read advance shows as stale
    always_ff @(posedge clk)
    begin
        if (state_q == ST_READ)
        begin
            fetch_index_q <= next_index;
        end
        if (state_q == ST_LATCH)
        begin
            held_entry_q <= rd_data_i;
            held_index_q <= fetch_index_q;
        end
        if (issue)
        begin
            trace_o       <= held_entry_q;
            trace_index_o <= held_index_q[TRACE_INDEX_WIDTH-1:0];
        end
    end

endmodule

//--- rtl/commit_tracker.sv
`timescale 1ns/1ps

module commit_tracker
#(
    parameter int ACTIVE_SET_ENTRIES = 8
)
(
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       lock_i,
    input  logic                                       mark_done_i,
    input  trace_repo_pkg::done_req_t                  done_req_i,
    output logic                                       mark_done_valid_o,
    output logic [trace_repo_pkg::TRACE_INDEX_WIDTH:0] committed_count_o,
    output trace_repo_pkg::outcome_counts_t            counts_o
);
    import trace_repo_pkg::*;

    localparam int PTR_WIDTH = (ACTIVE_SET_ENTRIES > 1) ? $clog2(ACTIVE_SET_ENTRIES) : 1;
    localparam int OCC_WIDTH = $clog2(ACTIVE_SET_ENTRIES + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(ACTIVE_SET_ENTRIES - 1);
    localparam logic [OCC_WIDTH-1:0] FULL_OCC  = OCC_WIDTH'(ACTIVE_SET_ENTRIES);

    // Each slot keeps the pushed report, its index, address and pre-emptive outcome
    done_req_t            active_set_q [ACTIVE_SET_ENTRIES];
    logic [PTR_WIDTH-1:0] push_ptr_q;
    logic [PTR_WIDTH-1:0] pop_ptr_q;
    logic [OCC_WIDTH-1:0] occupancy_q;
    done_req_t            popped;
    logic                 as_full;
    logic                 as_empty;
    logic                 accept;
    logic                 preemptive;
    logic                 push;
    logic                 pop;
    logic                 plain;

    function automatic logic [PTR_WIDTH-1:0] wrap_inc(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == LAST_SLOT)
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign as_full  = (occupancy_q == FULL_OCC);
    assign as_empty = (occupancy_q == '0);
    assign popped   = active_set_q[pop_ptr_q];

    // A report still held during the valid pulse waits one cycle
    assign accept     = lock_i && mark_done_i && !mark_done_valid_o;
    assign preemptive = done_req_i.mem_trace && done_req_i.processing;
    assign push       = accept && preemptive && !as_full;
    assign pop        = accept && !done_req_i.mem_trace && !as_empty;
    assign plain      = accept && !preemptive && !pop;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            active_set_q[push_ptr_q] <= done_req_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            push_ptr_q        <= '0;
            pop_ptr_q         <= '0;
            occupancy_q       <= '0;
            mark_done_valid_o <= 1'b0;
            committed_count_o <= '0;
            counts_o          <= '0;
        end
        else
        begin
            mark_done_valid_o <= accept;
            if (push)
            begin
                push_ptr_q  <= wrap_inc(push_ptr_q);
                occupancy_q <= occupancy_q + 1'b1;
            end
            if (pop)
            begin
                pop_ptr_q         <= wrap_inc(pop_ptr_q);
                occupancy_q       <= occupancy_q - 1'b1;
                committed_count_o <= committed_count_o + 1'b1;
                // A system miss after a pre-emptive run is not classified
                if (!done_req_i.hit_miss)
                begin
                    if (popped.hit_miss)
                    begin
                        if (done_req_i.load_store)
                            counts_o.hpm_s <= counts_o.hpm_s + 1'b1;
                        else
                            counts_o.hpm_l <= counts_o.hpm_l + 1'b1;
                    end
                    else
                    begin
                        if (done_req_i.load_store)
                            counts_o.hph_s <= counts_o.hph_s + 1'b1;
                        else
                            counts_o.hph_l <= counts_o.hph_l + 1'b1;
                    end
                end
            end
            if (plain)
            begin
                committed_count_o <= committed_count_o + 1'b1;
                case ({done_req_i.hit_miss, done_req_i.load_store})
                    2'b00:   counts_o.h_l <= counts_o.h_l + 1'b1;
                    2'b01:   counts_o.h_s <= counts_o.h_s + 1'b1;
                    2'b10:   counts_o.m_l <= counts_o.m_l + 1'b1;
                    default: counts_o.m_s <= counts_o.m_s + 1'b1;
                endcase
            end
        end
    end

endmodule

//--- rtl/nway_trace_repository.sv
`timescale 1ns/1ps

module nway_trace_repository
#(
    parameter int ACTIVE_SET_ENTRIES = 8
)
(
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        lock_i,
    input  trace_repo_pkg::trace_entry_t                trace_i,
    input  logic                                        capture_en_i,
    input  logic                                        trace_ready_i,
    input  logic                                        trace_req_i,
    input  logic                                        mark_done_i,
    input  trace_repo_pkg::done_req_t                   done_req_i,
    output trace_repo_pkg::trace_entry_t                trace_o,
    output logic [trace_repo_pkg::TRACE_INDEX_WIDTH-1:0] trace_index_o,
    output logic                                        entry_valid_o,
    output logic                                        processing_complete_o,
    output logic                                        mark_done_valid_o,
    output trace_repo_pkg::outcome_counts_t             counts_o
);
    import trace_repo_pkg::*;

    logic                         capture_wr;
    logic                         rd_en;
    logic [TRACE_INDEX_WIDTH-1:0] rd_addr;
    trace_entry_t                 rd_data;
    logic [TRACE_INDEX_WIDTH:0]   capture_count;
    logic [TRACE_INDEX_WIDTH:0]   committed_count;

    // Capture only runs before the store is locked
    assign capture_wr = capture_en_i && trace_ready_i && !lock_i;

    trace_memory u_memory
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .wr_en_i         (capture_wr),
        .wr_data_i       (trace_i),
        .rd_en_i         (rd_en),
        .rd_addr_i       (rd_addr),
        .rd_data_o       (rd_data),
        .capture_count_o (capture_count)
    );

    trace_fetch u_fetch
    (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .lock_i                (lock_i),
        .trace_req_i           (trace_req_i),
        .done_accept_i         (mark_done_valid_o),
        .capture_count_i       (capture_count),
        .committed_count_i     (committed_count),
        .rd_data_i             (rd_data),
        .rd_en_o               (rd_en),
        .rd_addr_o             (rd_addr),
        .trace_o               (trace_o),
        .trace_index_o         (trace_index_o),
        .entry_valid_o         (entry_valid_o),
        .processing_complete_o (processing_complete_o)
    );

    commit_tracker #(
        .ACTIVE_SET_ENTRIES (ACTIVE_SET_ENTRIES)
    ) u_commit
    (
        .clk               (clk),
        .rst_n             (rst_n),
        .lock_i            (lock_i),
        .mark_done_i       (mark_done_i),
        .done_req_i        (done_req_i),
        .mark_done_valid_o (mark_done_valid_o),
        .committed_count_o (committed_count),
        .counts_o          (counts_o)
    );

endmodule

//--- verification/trace_repository_sva.sv
`timescale 1ns/1ps

module trace_repository_sva
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      lock_i,
    input logic                      mark_done_i,
    input trace_repo_pkg::done_req_t done_req_i,
    input logic                      entry_valid_i,
    input logic                      processing_complete_i,
    input logic                      mark_done_valid_i,
    input logic                      active_set_full_i
);

    logic preemptive_accept;

    // Same acceptance rule as the commit tracker, limited to pre-emptive reports
    assign preemptive_accept = lock_i && mark_done_i && !mark_done_valid_i
                               && done_req_i.mem_trace && done_req_i.processing;

    valid_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mark_done_valid_i |=> !mark_done_valid_i)
        else $error("mark_done_valid_o stayed high for two cycles");

    issue_or_complete: assert property (@(posedge clk) disable iff (!rst_n)
        !(entry_valid_i && processing_complete_i))
        else $error("entry_valid_o and processing_complete_o are high together");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        preemptive_accept |-> !active_set_full_i)
        else $error("Pre-emptive report arrived while the active set was full");

endmodule

bind nway_trace_repository trace_repository_sva u_sva
(
    .clk                   (clk),
    .rst_n                 (rst_n),
    .lock_i                (lock_i),
    .mark_done_i           (mark_done_i),
    .done_req_i            (done_req_i),
    .entry_valid_i         (entry_valid_o),
    .processing_complete_i (processing_complete_o),
    .mark_done_valid_i     (mark_done_valid_o),
    .active_set_full_i     (u_commit.as_full)
);

//--- verification/tb_trace_repository.sv
`timescale 1ns/1ps

module tb_trace_repository;
    import trace_repo_pkg::*;

    localparam int MAX_RECORDS       = 64;
    localparam int NUM_FIELDS        = 14;
    localparam int CYCLES_PER_RECORD = 200;

    logic                         clk;
    logic                         rst_n;
    logic                         lock_i;
    trace_entry_t                 trace_i;
    logic                         capture_en_i;
    logic                         trace_ready_i;
    logic                         trace_req_i;
    logic                         mark_done_i;
    done_req_t                    done_req_i;
    trace_entry_t                 trace_o;
    logic [TRACE_INDEX_WIDTH-1:0] trace_index_o;
    logic                         entry_valid_o;
    logic                         processing_complete_o;
    logic                         mark_done_valid_o;
    outcome_counts_t              counts_o;

    string       ops [MAX_RECORDS];
    logic [31:0] fields [MAX_RECORDS][NUM_FIELDS];
    string       counter_names [8] = '{"h_l", "hph_l", "hpm_l", "h_s",
                                       "hph_s", "hpm_s", "m_l", "m_s"};
    int          num_records = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          seed;

    nway_trace_repository #(
        .ACTIVE_SET_ENTRIES (4)
    ) uut (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s expected %0h got %0h",
                               $time, what, expected, actual));
        end
    endtask

    // Limit scales with the number of records once the vector file is loaded
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            stop_run($sformatf("Timeout: the run did not finish within %0d cycles",
                               cycle_limit));
        end
    end

    function automatic int field_count(input string op);
        case (op)
            "C":     return 2;
            "L":     return 0;
            "R":     return 4;
            "M":     return NUM_FIELDS;
            default: return -1;
        endcase
    endfunction

    task automatic capture_entry(input int rec);
        trace_i.mem_addr    = fields[rec][0][DATA_ADDR_WIDTH-1:0];
        trace_i.instruction = fields[rec][1];
        capture_en_i        = 1'b1;
        trace_ready_i       = 1'b1;
        @(negedge clk);
        capture_en_i  = 1'b0;
        trace_ready_i = 1'b0;
    endtask

    // Holds the request until either an entry or the completion level shows up
    task automatic request_entry(input int rec);
        trace_req_i = 1'b1;
        @(negedge clk);
        while (!entry_valid_o && !processing_complete_o)
        begin
            @(negedge clk);
        end
        trace_req_i = 1'b0;
        check_value(64'(entry_valid_o), 64'(fields[rec][0]), "response is an entry");
        if (fields[rec][0] == 32'd1)
        begin
            check_value(64'(trace_index_o), 64'(fields[rec][1]), "trace_index_o");
            check_value(64'(trace_o.mem_addr), 64'(fields[rec][2]), "trace_o.mem_addr");
            check_value(64'(trace_o.instruction), 64'(fields[rec][3]), "trace_o.instruction");
        end
        @(negedge clk);
        check_value(64'(entry_valid_o), 64'd0, "entry_valid_o after the request");
        check_value(64'(processing_complete_o), 64'd0, "processing_complete_o after the request");
    endtask

    task automatic mark_done(input int rec);
        done_req_i.index_done = fields[rec][0][TRACE_INDEX_WIDTH-1:0];
        done_req_i.mem_addr   = fields[rec][1][DATA_ADDR_WIDTH-1:0];
        done_req_i.processing = fields[rec][2][0];
        done_req_i.mem_trace  = fields[rec][3][0];
        done_req_i.hit_miss   = fields[rec][4][0];
        done_req_i.load_store = fields[rec][5][0];
        mark_done_i           = 1'b1;
        @(negedge clk);
        mark_done_i = 1'b0;
        check_value(64'(mark_done_valid_o), 64'd1, "mark_done_valid_o one cycle after mark");
        // Counters sit in the struct from h_l at the top down to m_s
        for (int i = 0; i < 8; i++)
        begin
            check_value(64'(counts_o[255 - 32 * i -: 32]), 64'(fields[rec][6 + i]),
                        {"counts_o.", counter_names[i]});
        end
        @(negedge clk);
        check_value(64'(mark_done_valid_o), 64'd0, "mark_done_valid_o drops after one cycle");
    endtask

    initial
    begin
        int    fd;
        int    code;
        int    nf;
        string op;
        string rest;

        rst_n         = 1'b0;
        lock_i        = 1'b0;
        trace_i       = '0;
        capture_en_i  = 1'b0;
        trace_ready_i = 1'b0;
        trace_req_i   = 1'b0;
        mark_done_i   = 1'b0;
        done_req_i    = '0;
        seed          = 3;

        fd = $fopen("verification/trace_vectors.txt", "r");
        if (fd == 0)
        begin
            stop_run("Could not open verification/trace_vectors.txt");
        end
        code = $fscanf(fd, "%s", op);
        while (code == 1)
        begin
            if (op == "#")
            begin
                code = $fgets(rest, fd);
            end
            else
            begin
                nf = field_count(op);
                if (nf < 0 || num_records >= MAX_RECORDS)
                begin
                    stop_run($sformatf("Bad or surplus record %s in the vector file", op));
                end
                for (int i = 0; i < nf; i++)
                begin
                    code = $fscanf(fd, "%h", fields[num_records][i]);
                    if (code != 1)
                    begin
                        stop_run("The vector file ended in the middle of a record");
                    end
                end
                ops[num_records] = op;
                num_records++;
            end
            code = $fscanf(fd, "%s", op);
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_RECORD * num_records;

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int rec = 0; rec < num_records; rec++)
        begin
            case (ops[rec])
                "C": capture_entry(rec);
                "R": request_entry(rec);
                "M": mark_done(rec);
                default:
                begin
                    lock_i = 1'b1;
                    @(negedge clk);
                end
            endcase
            // A short random gap shifts the records against the fetch pipeline
            repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- verification/trace_vectors.txt
# C mem_addr instruction | L | R kind (1 entry, 0 complete) index mem_addr instruction
# M index mem_addr processing mem_trace hit_miss load_store h_l hph_l hpm_l h_s hph_s hpm_s m_l m_s
C 1000 00a00093
C 1004 00b00113
C 1008 002081b3
C 100c 40208233
C 1010 0030a023
C 1014 0040a283
C 1018 00512023
C 101c 00c0006f
L
R 1 00 1000 00a00093
M 00 1000 0 0 0 0 1 0 0 0 0 0 0 0
R 1 01 1004 00b00113
M 01 1004 0 1 1 1 1 0 0 0 0 0 0 1
R 1 02 1008 002081b3
M 02 1008 0 0 0 1 1 0 0 1 0 0 0 1
R 1 03 100c 40208233
M 03 100c 0 1 1 0 1 0 0 1 0 0 1 1
# Four pre-emptive reports fill the active set, then four system reports drain it
M 04 1010 1 1 1 0 1 0 0 1 0 0 1 1
M 05 1014 1 1 0 1 1 0 0 1 0 0 1 1
M 06 1018 1 1 1 1 1 0 0 1 0 0 1 1
M 07 101c 1 1 0 0 1 0 0 1 0 0 1 1
M 04 1010 0 0 0 0 1 0 1 1 0 0 1 1
M 05 1014 0 0 0 1 1 0 1 1 1 0 1 1
M 06 1018 0 0 0 1 1 0 1 1 1 1 1 1
M 07 101c 0 0 1 0 1 0 1 1 1 1 1 1
R 0 00 0000 00000000

//--- all.f
rtl/trace_repo_pkg.sv
rtl/trace_memory.sv
rtl/trace_fetch.sv
rtl/commit_tracker.sv
rtl/nway_trace_repository.sv
verification/trace_repository_sva.sv
verification/tb_trace_repository.sv

//--- Makefile
TOP = tb_trace_repository

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
